//--- common/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Machine word and register file
`define RW          16
`define REGNO       8
`define REGNO_LOG   3

// Flag bit positions inside the flags register
`define ALU_FLAG_CNT 5
`define ALU_FLAG_C  0
`define ALU_FLAG_Z  1
`define ALU_FLAG_N  2
`define ALU_FLAG_O  3
`define ALU_FLAG_P  4

`define DMEM_DEPTH  64

// Top bit marks a valid jump
`define JUMP_CODE_W 5

`endif

//--- common/cpu_pkg.sv
`include "cpu_config.svh"

package cpu_pkg;

    typedef logic [`RW-1:0] word_t;
    typedef logic [`REGNO_LOG-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        OP_NOP, OP_ADD, OP_SUB, OP_ADC, OP_AND, OP_OR,
        OP_XOR, OP_ADDI, OP_LDI, OP_LD, OP_ST, OP_JMP
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_ADC, ALU_AND, ALU_OR, ALU_XOR, ALU_PASS_R
    } alu_mode_t;

    typedef enum logic [`JUMP_CODE_W-1:0] {
        JC_NONE   = 5'b00000,
        JC_UNCOND = 5'b10000,
        JC_CARRY  = 5'b10001,
        JC_EQUAL  = 5'b10010,
        JC_LT     = 5'b10011,
        JC_GT     = 5'b10100,
        JC_LE     = 5'b10101,
        JC_GE     = 5'b10110,
        JC_NE     = 5'b10111,
        JC_OVF    = 5'b11000,
        JC_PAR    = 5'b11001
    } jump_code_t;

    // One instruction word, three views selected by the opcode
    typedef union packed {
        struct packed {opcode_t opcode; reg_idx_t rd, rl, rr; logic [2:0] unused;} reg_form;
        struct packed {opcode_t opcode; reg_idx_t rd, rl; logic signed [5:0] imm;} imm_form;
        struct packed {opcode_t opcode; logic [3:0] cond; logic signed [7:0] offset;} jump_form;
    } instr_u;

endpackage

//--- rtl/fetch.sv
`timescale 1ns/1ps

module fetch import cpu_pkg::*; (
    input  logic   i_clk,
    input  logic   i_rst,
    input  logic   i_flush,
    input  word_t  i_target,
    output word_t  o_imem_addr,
    input  instr_u i_imem_data,
    output instr_u o_instr,
    output word_t  o_pc,
    output logic   o_submit,
    input  logic   i_ready
);

    word_t pc_q;
    logic  take;

    assign o_imem_addr = pc_q;
    // Entry is free or leaves this cycle
    assign take = ~o_submit | i_ready;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc_q     <= '0;
            o_submit <= 1'b0;
        end else if (i_flush) begin
            pc_q     <= i_target;
            o_submit <= 1'b0;
        end else if (take) begin
            o_instr  <= i_imem_data;
            o_pc     <= pc_q;
            o_submit <= 1'b1;
            pc_q     <= pc_q + 1'b1;
        end
    end

    // Flush is a one-cycle pulse and leaves no entry behind
    assert property (@(posedge i_clk) disable iff (i_rst) i_flush |=> !(o_submit || i_flush));

endmodule

//--- rtl/decode.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module decode import cpu_pkg::*; (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_flush,
    input  instr_u            i_instr,
    input  word_t             i_pc,
    input  logic              i_submit,
    output logic              o_ready,
    input  logic              i_ready,
    output logic              o_submit,
    output word_t             o_pc,
    output word_t             o_imm,
    output logic              o_r_bus_imm,
    output alu_mode_t         o_alu_mode,
    output logic              o_alu_carry_en,
    output logic              o_flags_ie,
    output reg_idx_t          o_l_reg_sel,
    output reg_idx_t          o_r_reg_sel,
    output logic [`REGNO-1:0] o_rf_ie,
    output jump_code_t        o_jump_code,
    output logic              o_mem_access,
    output logic              o_mem_we,
    output logic [1:0]        o_used_operands
);

    opcode_t op;
    logic    is_reg_op;

    assign op        = i_instr.reg_form.opcode;
    assign is_reg_op = op inside {OP_ADD, OP_SUB, OP_ADC, OP_AND, OP_OR, OP_XOR};
    // Hold register stays while execute stalls
    assign o_ready   = ~o_submit | i_ready;

    always_ff @(posedge i_clk) begin
        if (i_rst || i_flush) begin
            o_submit <= 1'b0;
        end else if (o_ready) begin
            o_submit <= i_submit;
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_ready && i_submit) begin
            o_pc            <= i_pc;
            o_imm           <= word_t'(i_instr.imm_form.imm);
            o_r_bus_imm     <= op inside {OP_ADDI, OP_LDI, OP_LD, OP_ST};
            o_alu_carry_en  <= op == OP_ADC;
            o_flags_ie      <= is_reg_op || op == OP_ADDI;
            o_l_reg_sel     <= i_instr.reg_form.rl;
            o_r_reg_sel     <= i_instr.reg_form.rr;
            o_rf_ie         <= '0;
            o_jump_code     <= JC_NONE;
            o_mem_access    <= op inside {OP_LD, OP_ST};
            o_mem_we        <= op == OP_ST;
            o_used_operands <= 2'b00;
            case (op)
                OP_ADD, OP_ADC: o_alu_mode <= (op == OP_ADC) ? ALU_ADC : ALU_ADD;
                OP_SUB:         o_alu_mode <= ALU_SUB;
                OP_AND:         o_alu_mode <= ALU_AND;
                OP_OR:          o_alu_mode <= ALU_OR;
                OP_XOR:         o_alu_mode <= ALU_XOR;
                OP_LDI:         o_alu_mode <= ALU_PASS_R;
                default:        o_alu_mode <= ALU_ADD;
            endcase
            if (is_reg_op) begin
                o_rf_ie[i_instr.reg_form.rd] <= 1'b1;
                o_used_operands              <= 2'b11;
            end else if (op inside {OP_ADDI, OP_LDI, OP_LD}) begin
                o_rf_ie[i_instr.imm_form.rd] <= 1'b1;
                o_used_operands              <= {1'b0, op != OP_LDI};
            end else if (op == OP_ST) begin
                // Store data comes from rd on the right port
                o_r_reg_sel     <= i_instr.imm_form.rd;
                o_used_operands <= 2'b11;
            end else if (op == OP_JMP) begin
                o_imm       <= word_t'(i_instr.jump_form.offset);
                o_jump_code <= jump_code_t'({1'b1, i_instr.jump_form.cond});
            end
        end
    end

endmodule

//--- execute/alu.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module alu import cpu_pkg::*; (
    input  word_t                    i_l,
    input  word_t                    i_r,
    input  alu_mode_t                i_mode,
    input  logic                     i_carry,
    output word_t                    o_out,
    output logic [`ALU_FLAG_CNT-1:0] o_flags
);

    logic [`RW:0] wide;
    logic         ovf;

    always_comb begin
        wide = '0;
        ovf  = 1'b0;
        case (i_mode)
            ALU_ADD, ALU_ADC: begin
                wide = {1'b0, i_l} + {1'b0, i_r} + (i_mode == ALU_ADC ? i_carry : 1'b0);
                ovf  = (i_l[`RW-1] == i_r[`RW-1]) && (wide[`RW-1] != i_l[`RW-1]);
            end
            ALU_SUB: begin
                // Bit 16 becomes the borrow
                wide = {1'b0, i_l} - {1'b0, i_r};
                ovf  = (i_l[`RW-1] != i_r[`RW-1]) && (wide[`RW-1] != i_l[`RW-1]);
            end
            ALU_AND:    wide[`RW-1:0] = i_l & i_r;
            ALU_OR:     wide[`RW-1:0] = i_l | i_r;
            ALU_XOR:    wide[`RW-1:0] = i_l ^ i_r;
            ALU_PASS_R: wide[`RW-1:0] = i_r;
            default:    wide = '0;
        endcase
    end

    assign o_out               = wide[`RW-1:0];
    assign o_flags[`ALU_FLAG_C] = wide[`RW];
    assign o_flags[`ALU_FLAG_Z] = o_out == '0;
    assign o_flags[`ALU_FLAG_N] = o_out[`RW-1];
    assign o_flags[`ALU_FLAG_O] = ovf;
    assign o_flags[`ALU_FLAG_P] = ~^o_out;

endmodule

//--- execute/register_file.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module register_file import cpu_pkg::*; (
    input  logic              i_clk,
    input  logic              i_rst,
    input  reg_idx_t          i_l_sel,
    input  reg_idx_t          i_r_sel,
    input  logic [`REGNO-1:0] i_ie,
    input  word_t             i_d,
    output word_t             o_l,
    output word_t             o_r
);

    word_t regs [`REGNO];

    always_ff @(posedge i_clk) begin
        for (int i = 0; i < `REGNO; i++) begin
            if (i_rst) begin
                regs[i] <= '0;
            end else if (i_ie[i]) begin
                regs[i] <= i_d;
            end
        end
    end

    // Write-through so the register being written is visible now
    assign o_l = i_ie[i_l_sel] ? i_d : regs[i_l_sel];
    assign o_r = i_ie[i_r_sel] ? i_d : regs[i_r_sel];

    assert property (@(posedge i_clk) disable iff (i_rst) $onehot0(i_ie));

endmodule

//--- execute/execute.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module execute import cpu_pkg::*; (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_submit,
    output logic              o_ready,
    output logic              o_flush,
    output word_t             o_target,
    input  word_t             i_pc,
    input  word_t             i_imm,
    input  logic              i_r_bus_imm,
    input  alu_mode_t         i_alu_mode,
    input  logic              i_alu_carry_en,
    input  logic              i_flags_ie,
    input  reg_idx_t          i_l_reg_sel,
    input  reg_idx_t          i_r_reg_sel,
    input  logic [`REGNO-1:0] i_rf_ie,
    input  jump_code_t        i_jump_code,
    input  logic              i_mem_access,
    input  logic              i_mem_we,
    input  logic [1:0]        i_used_operands,
    output word_t             o_data,
    output word_t             o_addr,
    output logic [`REGNO-1:0] o_reg_ie,
    output logic              o_mem_access,
    output logic              o_mem_we,
    output word_t             o_pc,
    output logic              o_submit,
    input  logic              i_next_ready,
    input  logic [`REGNO-1:0] i_reg_ie,
    input  word_t             i_reg_data
);

    logic next_ready_delayed;
    logic raw_hazard;
    logic i_valid;
    logic hold_valid;
    logic instr_valid;
    logic exec_submit;
    logic jump_taken;
    logic jump_dec_en;
    word_t reg_l, reg_r, alu_r_bus, alu_bus;
    logic [`ALU_FLAG_CNT-1:0] flags_d, flags_q;

    // Destination of the last submitted instruction is not yet readable.
    // A busy write-back stage also means the load result is still pending.
    assign raw_hazard = ((i_used_operands[0] & o_reg_ie[i_l_reg_sel]) |
                         (i_used_operands[1] & o_reg_ie[i_r_reg_sel])) &
                        (o_submit | ~next_ready_delayed | ~i_next_ready);

    assign i_valid     = i_submit & ~o_flush;
    assign instr_valid = i_valid | (hold_valid & ~i_submit & ~o_flush);
    assign exec_submit = i_next_ready & instr_valid & ~raw_hazard;
    assign o_ready     = exec_submit | ~instr_valid;

    always_ff @(posedge i_clk) begin
        if (i_rst || o_flush || exec_submit) begin
            hold_valid <= 1'b0;
        end else if (i_valid) begin
            hold_valid <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            next_ready_delayed <= 1'b0;
        end else begin
            next_ready_delayed <= i_next_ready;
        end
    end

    assign alu_r_bus = i_r_bus_imm ? i_imm : reg_r;

    register_file u_register_file (
        .i_clk(i_clk), .i_rst(i_rst), .i_l_sel(i_l_reg_sel), .i_r_sel(i_r_reg_sel),
        .i_ie(i_reg_ie), .i_d(i_reg_data), .o_l(reg_l), .o_r(reg_r)
    );

    alu u_alu (
        .i_l(reg_l), .i_r(alu_r_bus), .i_mode(i_alu_mode),
        .i_carry(flags_q[`ALU_FLAG_C] & i_alu_carry_en), .o_out(alu_bus), .o_flags(flags_d)
    );

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            flags_q <= '0;
        end else if (i_flags_ie && exec_submit) begin
            flags_q <= flags_d;
        end
    end

    // Condition decode
    always_comb begin
        case (i_jump_code)
            JC_UNCOND: jump_dec_en = 1'b1;
            JC_CARRY:  jump_dec_en = flags_q[`ALU_FLAG_C];
            JC_EQUAL:  jump_dec_en = flags_q[`ALU_FLAG_Z];
            JC_LT:     jump_dec_en = flags_q[`ALU_FLAG_N];
            JC_GT:     jump_dec_en = ~(flags_q[`ALU_FLAG_N] | flags_q[`ALU_FLAG_Z]);
            JC_LE:     jump_dec_en = flags_q[`ALU_FLAG_N] | flags_q[`ALU_FLAG_Z];
            JC_GE:     jump_dec_en = ~flags_q[`ALU_FLAG_N];
            JC_NE:     jump_dec_en = ~flags_q[`ALU_FLAG_Z];
            JC_OVF:    jump_dec_en = flags_q[`ALU_FLAG_O];
            JC_PAR:    jump_dec_en = flags_q[`ALU_FLAG_P];
            default:   jump_dec_en = 1'b0;
        endcase
    end

    // Not-taken is predicted, so every taken jump redirects
    assign jump_taken = i_jump_code[`JUMP_CODE_W-1] & jump_dec_en;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_flush      <= 1'b0;
            o_submit     <= 1'b0;
            o_reg_ie     <= '0;
            o_mem_access <= 1'b0;
            o_mem_we     <= 1'b0;
        end else begin
            o_flush  <= jump_taken & exec_submit;
            o_submit <= exec_submit;
            if (exec_submit) begin
                o_reg_ie     <= i_rf_ie;
                o_mem_access <= i_mem_access;
                o_mem_we     <= i_mem_we;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (exec_submit) begin
            o_addr   <= alu_bus;
            o_data   <= i_mem_access ? reg_r : alu_bus;
            o_pc     <= i_pc;
            o_target <= i_pc + 1'b1 + i_imm;
        end
    end

    // The flushing jump occupies the output register and writes nothing
    assert property (@(posedge i_clk) disable iff (i_rst)
        o_flush |-> (o_submit && o_reg_ie == '0 && !o_mem_access));
    // Neither this stage nor decode passes on a wrong-path instruction
    assert property (@(posedge i_clk) disable iff (i_rst) o_flush |=> !(o_submit || i_submit));

endmodule

//--- rtl/mem_writeback.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module mem_writeback import cpu_pkg::*; (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_submit,
    output logic              o_ready,
    input  word_t             i_addr,
    input  word_t             i_data,
    input  logic [`REGNO-1:0] i_reg_ie,
    input  logic              i_mem_access,
    input  logic              i_mem_we,
    input  word_t             i_pc,
    output logic [`REGNO-1:0] o_reg_ie,
    output word_t             o_reg_data,
    output logic              o_retire_valid,
    output word_t             o_retire_pc,
    output logic              o_retire_we,
    output reg_idx_t          o_retire_reg,
    output word_t             o_retire_data,
    output logic              o_store_valid,
    output word_t             o_store_addr,
    output word_t             o_store_data
);

    localparam int AW = $clog2(`DMEM_DEPTH);

    word_t dmem [`DMEM_DEPTH] = '{default: '0};
    logic busy, fire, is_load, is_store;
    logic [`REGNO-1:0] reg_ie_q;
    word_t pc_q, rdata_q;

    // A load accepted now also blocks the next arrival
    assign o_ready  = ~busy & ~(fire & is_load);
    assign fire     = i_submit & ~busy;
    assign is_load  = i_mem_access & ~i_mem_we;
    assign is_store = i_mem_access & i_mem_we;

    always_ff @(posedge i_clk) begin
        if (fire && is_store) begin
            dmem[i_addr[AW-1:0]] <= i_data;
        end
        if (fire && is_load) begin
            rdata_q <= dmem[i_addr[AW-1:0]];
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            busy           <= 1'b0;
            o_reg_ie       <= '0;
            o_retire_valid <= 1'b0;
            o_store_valid  <= 1'b0;
        end else begin
            o_store_valid  <= fire & is_store;
            busy           <= fire & is_load;
            // Loads retire one cycle later from the held record
            o_retire_valid <= busy | (fire & ~is_load);
            o_reg_ie       <= busy ? reg_ie_q : ((fire & ~is_load) ? i_reg_ie : '0);
        end
    end

    always_ff @(posedge i_clk) begin
        if (busy) begin
            o_reg_data  <= rdata_q;
            o_retire_pc <= pc_q;
        end else if (fire) begin
            o_reg_data   <= i_data;
            o_retire_pc  <= i_pc;
            reg_ie_q     <= i_reg_ie;
            pc_q         <= i_pc;
            o_store_addr <= word_t'(i_addr[AW-1:0]);
            o_store_data <= i_data;
        end
    end

    always_comb begin
        o_retire_reg = '0;
        for (int i = 0; i < `REGNO; i++) begin
            if (o_reg_ie[i]) begin
                o_retire_reg = reg_idx_t'(i);
            end
        end
    end

    assign o_retire_we   = |o_reg_ie;
    assign o_retire_data = o_reg_data;

    // No store arrives while a load is still pending
    assert property (@(posedge i_clk) disable iff (i_rst) !(busy && i_submit && is_store));

endmodule

//--- rtl/cpu_top.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_top import cpu_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst,
    input  instr_u   i_imem_data,
    output word_t    o_imem_addr,
    output logic     o_retire_valid,
    output word_t    o_retire_pc,
    output logic     o_retire_we,
    output reg_idx_t o_retire_reg,
    output word_t    o_retire_data,
    output logic     o_store_valid,
    output word_t    o_store_addr,
    output word_t    o_store_data
);

    logic flush, f_submit, d_ready, d_submit, e_ready, e_submit, m_ready;
    word_t target, f_pc, d_pc, d_imm, e_data, e_addr, e_pc, wb_data;
    instr_u f_instr;
    logic d_r_bus_imm, d_carry_en, d_flags_ie, d_mem_access, d_mem_we;
    logic e_mem_access, e_mem_we;
    alu_mode_t d_alu_mode;
    reg_idx_t d_l_sel, d_r_sel;
    logic [`REGNO-1:0] d_rf_ie, e_reg_ie, wb_reg_ie;
    jump_code_t d_jump_code;
    logic [1:0] d_used;

    fetch u_fetch (
        .i_clk(i_clk), .i_rst(i_rst), .i_flush(flush), .i_target(target),
        .o_imem_addr(o_imem_addr), .i_imem_data(i_imem_data), .o_instr(f_instr),
        .o_pc(f_pc), .o_submit(f_submit), .i_ready(d_ready)
    );

    decode u_decode (
        .i_clk(i_clk), .i_rst(i_rst), .i_flush(flush), .i_instr(f_instr), .i_pc(f_pc),
        .i_submit(f_submit), .o_ready(d_ready), .i_ready(e_ready), .o_submit(d_submit),
        .o_pc(d_pc), .o_imm(d_imm), .o_r_bus_imm(d_r_bus_imm), .o_alu_mode(d_alu_mode),
        .o_alu_carry_en(d_carry_en), .o_flags_ie(d_flags_ie), .o_l_reg_sel(d_l_sel),
        .o_r_reg_sel(d_r_sel), .o_rf_ie(d_rf_ie), .o_jump_code(d_jump_code),
        .o_mem_access(d_mem_access), .o_mem_we(d_mem_we), .o_used_operands(d_used)
    );

    execute u_execute (
        .i_clk(i_clk), .i_rst(i_rst), .i_submit(d_submit), .o_ready(e_ready),
        .o_flush(flush), .o_target(target), .i_pc(d_pc), .i_imm(d_imm),
        .i_r_bus_imm(d_r_bus_imm), .i_alu_mode(d_alu_mode), .i_alu_carry_en(d_carry_en),
        .i_flags_ie(d_flags_ie), .i_l_reg_sel(d_l_sel), .i_r_reg_sel(d_r_sel),
        .i_rf_ie(d_rf_ie), .i_jump_code(d_jump_code), .i_mem_access(d_mem_access),
        .i_mem_we(d_mem_we), .i_used_operands(d_used), .o_data(e_data), .o_addr(e_addr),
        .o_reg_ie(e_reg_ie), .o_mem_access(e_mem_access), .o_mem_we(e_mem_we),
        .o_pc(e_pc), .o_submit(e_submit), .i_next_ready(m_ready),
        .i_reg_ie(wb_reg_ie), .i_reg_data(wb_data)
    );

    mem_writeback u_mem_writeback (
        .i_clk(i_clk), .i_rst(i_rst), .i_submit(e_submit), .o_ready(m_ready),
        .i_addr(e_addr), .i_data(e_data), .i_reg_ie(e_reg_ie),
        .i_mem_access(e_mem_access), .i_mem_we(e_mem_we), .i_pc(e_pc),
        .o_reg_ie(wb_reg_ie), .o_reg_data(wb_data), .o_retire_valid(o_retire_valid),
        .o_retire_pc(o_retire_pc), .o_retire_we(o_retire_we), .o_retire_reg(o_retire_reg),
        .o_retire_data(o_retire_data), .o_store_valid(o_store_valid),
        .o_store_addr(o_store_addr), .o_store_data(o_store_data)
    );

endmodule

//--- verification/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_tb import cpu_pkg::*;;

    localparam int PROG_LEN  = 300;
    localparam int CLK_NS    = 20;
    localparam int N_TESTS   = 6;
    localparam int T_RESET   = 0;
    localparam int T_ALU_REG = 1;
    localparam int T_ALU_IMM = 2;
    localparam int T_MEMORY  = 3;
    localparam int T_FLOW    = 4;
    localparam int T_HAZARD  = 5;

    typedef struct packed {
        word_t      pc;
        logic       we;
        reg_idx_t   rd;
        word_t      data;
        logic [2:0] test;
    } retire_t;

    typedef struct packed {
        word_t addr;
        word_t data;
    } store_t;

    logic     clk;
    logic     rst;
    instr_u   imem_data;
    word_t    imem_addr, retire_pc, retire_data, store_addr, store_data;
    logic     retire_valid, retire_we, store_valid;
    reg_idx_t retire_reg;

    instr_u  prog [PROG_LEN];
    retire_t exp_q [$];
    store_t  store_q [$];
    int      checks [N_TESTS];
    int      errors [N_TESTS];
    integer  seed = 32'hdb3f;
    bit      first_retire = 1'b1;

    cpu_top i_dut (
        .i_clk(clk), .i_rst(rst), .i_imem_data(imem_data), .o_imem_addr(imem_addr),
        .o_retire_valid(retire_valid), .o_retire_pc(retire_pc), .o_retire_we(retire_we),
        .o_retire_reg(retire_reg), .o_retire_data(retire_data), .o_store_valid(store_valid),
        .o_store_addr(store_addr), .o_store_data(store_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // Eight cycles per program instruction is far beyond the worst stall pattern
    initial begin
        #(PROG_LEN * 8 * CLK_NS);
        $display("Timeout: the pipeline did not retire the whole program in time");
        $display("=== FAIL ===");
        $finish;
    end

    // Instruction port answers the fetch address of this cycle, NOPs past the end
    always @(negedge clk) begin
        imem_data <= (imem_addr < PROG_LEN) ? prog[imem_addr] : instr_u'(16'h0000);
    end

    function automatic string test_name(input int t);
        case (t)
            T_RESET:   return "reset";
            T_ALU_REG: return "alu_reg";
            T_ALU_IMM: return "alu_imm";
            T_MEMORY:  return "memory";
            T_FLOW:    return "control_flow";
            default:   return "hazard";
        endcase
    endfunction

    task automatic check_word(input int t, input string what, input word_t exp, input word_t act);
        checks[t]++;
        if (exp !== act) begin
            errors[t]++;
            $display("FAIL %s %s: expected %h actual %h", test_name(t), what, exp, act);
        end
    endtask

    task automatic check_reg(input int t, input string what, input reg_idx_t exp,
                             input reg_idx_t act);
        checks[t]++;
        if (exp !== act) begin
            errors[t]++;
            $display("FAIL %s %s: expected %0d actual %0d", test_name(t), what, exp, act);
        end
    endtask

    task automatic check_flag(input int t, input string what, input bit exp, input bit act);
        checks[t]++;
        if (exp !== act) begin
            errors[t]++;
            $display("FAIL %s %s: expected %b actual %b", test_name(t), what, exp, act);
        end
    endtask

    task automatic generate_program();
        logic [31:0] r;
        opcode_t     op;
        instr_u      w;
        for (int i = 0; i < PROG_LEN; i++) begin
            r  = $random(seed);
            w  = r[15:0];
            op = opcode_t'(4'(r[31:16] % 12));
            w.reg_form.opcode = op;
            // Jumps only go forward so the program always runs off its end
            if (op == OP_JMP) begin
                r = $random(seed);
                w.jump_form.cond   = 4'(r[7:0] % 10);
                w.jump_form.offset = 8'(r[15:8] % 6);
            end
            prog[i] = w;
        end
    endtask

    // Sequential ISA model producing the in-order retirement and store streams
    task automatic run_model();
        word_t        regs [`REGNO];
        word_t        dmem [`DMEM_DEPTH];
        word_t        pc, a, b, res, imm, addr;
        logic [`RW:0] sum;
        logic         fc, fz, fn, fo, fp, take, reg_op, reads_prev;
        instr_u       ins;
        opcode_t      op;
        retire_t      e;
        int           last_rd;
        regs = '{default: '0};
        dmem = '{default: '0};
        {fc, fz, fn, fo, fp} = '0;
        pc = '0;
        last_rd = -1;
        while (pc < PROG_LEN) begin
            ins    = prog[pc];
            op     = ins.reg_form.opcode;
            reg_op = op inside {OP_ADD, OP_SUB, OP_ADC, OP_AND, OP_OR, OP_XOR};
            imm    = {{(`RW-6){ins.imm_form.imm[5]}}, ins.imm_form.imm};
            a      = regs[ins.reg_form.rl];
            b      = (op == OP_ADDI) ? imm : regs[ins.reg_form.rr];
            res    = '0;
            e      = '0;
            e.pc   = pc;
            e.rd   = ins.reg_form.rd;
            e.we   = reg_op || op inside {OP_ADDI, OP_LDI, OP_LD};
            reads_prev = (last_rd >= 0) &&
                (((reg_op || op inside {OP_ADDI, OP_LD, OP_ST}) && ins.reg_form.rl == last_rd) ||
                 (reg_op && ins.reg_form.rr == last_rd) ||
                 (op == OP_ST && ins.reg_form.rd == last_rd));
            pc = pc + 1'b1;
            case (op)
                OP_ADD, OP_ADC, OP_ADDI: begin
                    sum = {1'b0, a} + {1'b0, b} + ((op == OP_ADC) ? fc : 1'b0);
                    res = sum[`RW-1:0];
                    fc  = sum[`RW];
                    fo  = (a[`RW-1] == b[`RW-1]) && (res[`RW-1] != a[`RW-1]);
                end
                OP_SUB: begin
                    res = a - b;
                    fc  = a < b;
                    fo  = (a[`RW-1] != b[`RW-1]) && (res[`RW-1] != a[`RW-1]);
                end
                OP_AND, OP_OR, OP_XOR: begin
                    res = (op == OP_AND) ? (a & b) : ((op == OP_OR) ? (a | b) : (a ^ b));
                    fc  = 1'b0;
                    fo  = 1'b0;
                end
                OP_LDI: res = imm;
                OP_LD:  res = dmem[(a + imm) % `DMEM_DEPTH];
                OP_ST: begin
                    addr = (a + imm) % `DMEM_DEPTH;
                    dmem[addr] = regs[ins.reg_form.rd];
                    store_q.push_back({addr, regs[ins.reg_form.rd]});
                end
                OP_JMP: begin
                    case (ins.jump_form.cond)
                        4'd0:    take = 1'b1;
                        4'd1:    take = fc;
                        4'd2:    take = fz;
                        4'd3:    take = fn;
                        4'd4:    take = !fn && !fz;
                        4'd5:    take = fn || fz;
                        4'd6:    take = !fn;
                        4'd7:    take = !fz;
                        4'd8:    take = fo;
                        default: take = fp;
                    endcase
                    if (take) begin
                        pc = pc + word_t'(ins.jump_form.offset);
                    end
                end
                default: ;
            endcase
            if (reg_op || op == OP_ADDI) begin
                fz = res == '0;
                fn = res[`RW-1];
                fp = ~^res;
            end
            if (e.we) begin
                regs[e.rd] = res;
            end
            e.data  = res;
            e.test  = reads_prev ? T_HAZARD : reg_op ? T_ALU_REG :
                      (op inside {OP_ADDI, OP_LDI}) ? T_ALU_IMM :
                      (op inside {OP_LD, OP_ST}) ? T_MEMORY : T_FLOW;
            last_rd = e.we ? int'(e.rd) : -1;
            exp_q.push_back(e);
        end
    endtask

    task automatic check_retire();
        retire_t e;
        // Retirements past the end of the model trace are the NOP tail
        if (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            if (first_retire) begin
                check_word(T_RESET, "first pc", '0, retire_pc);
                first_retire = 1'b0;
            end
            check_word(T_FLOW, "pc", e.pc, retire_pc);
            check_flag(e.test, "write enable", e.we, retire_we);
            if (e.we) begin
                check_reg(e.test, "dest reg", e.rd, retire_reg);
                check_word(e.test, "result", e.data, retire_data);
            end
        end
    endtask

    task automatic check_store();
        store_t s;
        if (store_q.size() == 0) begin
            errors[T_MEMORY]++;
            $display("Store to address %h that the model never made", store_addr);
        end else begin
            s = store_q.pop_front();
            check_word(T_MEMORY, "store addr", s.addr, store_addr);
            check_word(T_MEMORY, "store data", s.data, store_data);
        end
    endtask

    always @(negedge clk) begin
        if (rst) begin
            checks[T_RESET]++;
            if (retire_valid) begin
                errors[T_RESET]++;
                $display("Retirement seen while reset is held");
            end
        end else begin
            if (retire_valid) begin
                check_retire();
            end
            if (store_valid) begin
                check_store();
            end
        end
    end

    initial begin
        int total_checks;
        int total_errors;
        rst = 1'b1;
        imem_data = '0;
        total_checks = 0;
        total_errors = 0;
        generate_program();
        run_model();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;
        while (exp_q.size() > 0 || store_q.size() > 0) begin
            @(negedge clk);
        end
        // A few more cycles so that a stray store still shows up
        repeat (4) @(posedge clk);
        for (int t = 0; t < N_TESTS; t++) begin
            $display("test %-12s done: %0d checks, %0d errors", test_name(t), checks[t], errors[t]);
            total_checks += checks[t];
            total_errors += errors[t];
        end
        $display("Total: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+common
common/cpu_pkg.sv
rtl/fetch.sv
rtl/decode.sv
execute/alu.sv
execute/register_file.sv
execute/execute.sv
rtl/mem_writeback.sv
rtl/cpu_top.sv
verification/cpu_tb.sv

//--- run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module cpu_tb -o cpu_sim \
    > sim.log 2>&1 && ./obj_dir/cpu_sim >> sim.log 2>&1 \
    || echo "=== FAIL ===" >> sim.log
cat sim.log
! grep -q "=== FAIL ===" sim.log
